// ==== all.f ====
hw/icache_cfg_pkg.sv
hw/icache_msg_pkg.sv
hw/icache_sram_1rw.sv
hw/icache_step_counter.sv
hw/icache_miss_fsm.sv
hw/icache_lookup_pipe.sv
hw/icache_replace.sv
hw/icache_top.sv
bench/icache_assertions.sv
bench/icache_tb.sv

// ==== bench/icache_assertions.sv ====
// cache protocol assertions
`timescale 1ns/1ns

module icache_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic fetch_ready_i,
  input logic data_v_i,
  input logic miss_req_v_i,
  input logic fill_v_i
);

  int fail_cnt = 0;
  logic [2:0] beats_left_r;

  // beats still owed for the open miss
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beats_left_r <= '0;
    end else if (miss_req_v_i) begin
      beats_left_r <= 3'd4;
    end else if (fill_v_i && (beats_left_r != '0)) begin
      beats_left_r <= beats_left_r - 1'b1;
    end
  end

  // no word comes back with the miss or while its line is filling
  a_no_data_with_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_i && (miss_req_v_i || (beats_left_r != '0))))
    else begin
      fail_cnt++;
      $error("data_v_o high with miss_req_v_o or during a fill");
    end

  a_miss_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_req_v_i |=> !miss_req_v_i)
    else begin
      fail_cnt++;
      $error("miss_req_v_o held for more than one cycle");
    end

  a_no_ready_in_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_req_v_i || (beats_left_r != '0)) |-> !fetch_ready_i)
    else begin
      fail_cnt++;
      $error("fetch_ready_o high before the four fill beats arrived");
    end

endmodule

bind icache_top icache_assertions asrt0 (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .fetch_ready_i (fetch_ready_o),
  .data_v_i      (data_v_o),
  .miss_req_v_i  (miss_req_v_o),
  .fill_v_i      (fill_v_i)
);

// ==== bench/icache_golden.hex ====
// first 256 words: line image, word index is {addr[12:10], addr[6:2]}
// then 25 fetches as pairs: fetch address, expected word
e1005a00 e1015a01 e1025a02 e1035a03 e1045a04 e1055a05 e1065a06 e1075a07
e1085a08 e1095a09 e10a5a0a e10b5a0b e10c5a0c e10d5a0d e10e5a0e e10f5a0f
e1105a10 e1115a11 e1125a12 e1135a13 e1145a14 e1155a15 e1165a16 e1175a17
e1185a18 e1195a19 e11a5a1a e11b5a1b e11c5a1c e11d5a1d e11e5a1e e11f5a1f
e1205a20 e1215a21 e1225a22 e1235a23 e1245a24 e1255a25 e1265a26 e1275a27
e1285a28 e1295a29 e12a5a2a e12b5a2b e12c5a2c e12d5a2d e12e5a2e e12f5a2f
e1305a30 e1315a31 e1325a32 e1335a33 e1345a34 e1355a35 e1365a36 e1375a37
e1385a38 e1395a39 e13a5a3a e13b5a3b e13c5a3c e13d5a3d e13e5a3e e13f5a3f
e1405a40 e1415a41 e1425a42 e1435a43 e1445a44 e1455a45 e1465a46 e1475a47
e1485a48 e1495a49 e14a5a4a e14b5a4b e14c5a4c e14d5a4d e14e5a4e e14f5a4f
e1505a50 e1515a51 e1525a52 e1535a53 e1545a54 e1555a55 e1565a56 e1575a57
e1585a58 e1595a59 e15a5a5a e15b5a5b e15c5a5c e15d5a5d e15e5a5e e15f5a5f
e1605a60 e1615a61 e1625a62 e1635a63 e1645a64 e1655a65 e1665a66 e1675a67
e1685a68 e1695a69 e16a5a6a e16b5a6b e16c5a6c e16d5a6d e16e5a6e e16f5a6f
e1705a70 e1715a71 e1725a72 e1735a73 e1745a74 e1755a75 e1765a76 e1775a77
e1785a78 e1795a79 e17a5a7a e17b5a7b e17c5a7c e17d5a7d e17e5a7e e17f5a7f
e1805a80 e1815a81 e1825a82 e1835a83 e1845a84 e1855a85 e1865a86 e1875a87
e1885a88 e1895a89 e18a5a8a e18b5a8b e18c5a8c e18d5a8d e18e5a8e e18f5a8f
e1905a90 e1915a91 e1925a92 e1935a93 e1945a94 e1955a95 e1965a96 e1975a97
e1985a98 e1995a99 e19a5a9a e19b5a9b e19c5a9c e19d5a9d e19e5a9e e19f5a9f
e1a05aa0 e1a15aa1 e1a25aa2 e1a35aa3 e1a45aa4 e1a55aa5 e1a65aa6 e1a75aa7
e1a85aa8 e1a95aa9 e1aa5aaa e1ab5aab e1ac5aac e1ad5aad e1ae5aae e1af5aaf
e1b05ab0 e1b15ab1 e1b25ab2 e1b35ab3 e1b45ab4 e1b55ab5 e1b65ab6 e1b75ab7
e1b85ab8 e1b95ab9 e1ba5aba e1bb5abb e1bc5abc e1bd5abd e1be5abe e1bf5abf
e1c05ac0 e1c15ac1 e1c25ac2 e1c35ac3 e1c45ac4 e1c55ac5 e1c65ac6 e1c75ac7
e1c85ac8 e1c95ac9 e1ca5aca e1cb5acb e1cc5acc e1cd5acd e1ce5ace e1cf5acf
e1d05ad0 e1d15ad1 e1d25ad2 e1d35ad3 e1d45ad4 e1d55ad5 e1d65ad6 e1d75ad7
e1d85ad8 e1d95ad9 e1da5ada e1db5adb e1dc5adc e1dd5add e1de5ade e1df5adf
e1e05ae0 e1e15ae1 e1e25ae2 e1e35ae3 e1e45ae4 e1e55ae5 e1e65ae6 e1e75ae7
e1e85ae8 e1e95ae9 e1ea5aea e1eb5aeb e1ec5aec e1ed5aed e1ee5aee e1ef5aef
e1f05af0 e1f15af1 e1f25af2 e1f35af3 e1f45af4 e1f55af5 e1f65af6 e1f75af7
e1f85af8 e1f95af9 e1fa5afa e1fb5afb e1fc5afc e1fd5afd e1fe5afe e1ff5aff
// fetch list, set 2 gets five tags
00000000 e1005a00 00000004 e1015a01 00000008 e1025a02
0000000c e1035a03 00000010 e1045a04 00000014 e1055a05
00000020 e1085a08 00000424 e1295a29 00000828 e14a5a4a
00000c2c e16b5a6b 00000020 e1085a08 00000828 e14a5a4a
00001024 e1895a89 00000424 e1295a29 00000c2c e16b5a6b
00001020 e1885a88 00000820 e1485a48 00000070 e11c5a1c
00000074 e11d5a1d 00000078 e11e5a1e 0000007c e11f5a1f
0000143c e1af5aaf 00000004 e1015a01 00001c34 e1ed5aed
00000014 e1055a05

// ==== bench/icache_tb.sv ====
// instruction cache testbench
`timescale 1ns/1ns

module icache_tb;

  localparam int IMAGE_WORDS = 256;
  localparam int N_FETCH = 25;
  localparam int GOLDEN_WORDS = IMAGE_WORDS + 2 * N_FETCH;
  localparam int SETS = icache_cfg_pkg::SETS;
  localparam int WAYS = icache_cfg_pkg::WAYS;
  localparam int WATCHDOG_NS = (SETS + N_FETCH * 20) * 10;

  logic clk_i;
  logic reset_i;
  logic fetch_v_i;
  icache_cfg_pkg::addr_t fetch_addr_i;
  logic fetch_ready_o;
  logic data_v_o;
  icache_cfg_pkg::word_t data_o;
  logic miss_req_v_o;
  icache_msg_pkg::miss_req_s miss_req_o;
  logic fill_v_i;
  icache_msg_pkg::fill_beat_s fill_i;

  // image words first, then address and expected word pairs
  logic [31:0] golden [GOLDEN_WORDS];
  logic [31:0] rng_state;

  // reference model of the tag arrays and tree bits
  logic model_valid [SETS][WAYS];
  icache_cfg_pkg::tag_t model_tag [SETS][WAYS];
  logic [2:0] model_tree [SETS];

  icache_top dut0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .data_v_o      (data_v_o),
    .data_o        (data_o),
    .miss_req_v_o  (miss_req_v_o),
    .miss_req_o    (miss_req_o),
    .fill_v_i      (fill_v_i),
    .fill_i        (fill_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s at %0t ns", why, $time);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // image holds 8 tags of sets 0 to 7
  function automatic icache_cfg_pkg::word_t image_word(input icache_cfg_pkg::addr_t a);
    return golden[{a[12:10], a[6:2]}];
  endfunction

  function automatic icache_cfg_pkg::index_t set_of(input icache_cfg_pkg::addr_t a);
    return a[icache_cfg_pkg::INDEX_LSB +: icache_cfg_pkg::INDEX_W];
  endfunction

  function automatic icache_cfg_pkg::tag_t tag_of(input icache_cfg_pkg::addr_t a);
    return a[icache_cfg_pkg::TAG_LSB +: icache_cfg_pkg::TAG_W];
  endfunction

  function automatic int model_hit_way(input icache_cfg_pkg::addr_t a);
    int found;
    found = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (model_valid[set_of(a)][w] && (model_tag[set_of(a)][w] == tag_of(a))) begin
        found = w;
      end
    end
    return found;
  endfunction

  // lowest invalid way, else follow the tree
  function automatic int model_victim(input icache_cfg_pkg::index_t s);
    int pick;
    logic [2:0] t;
    t = model_tree[s];
    if (t[0]) begin
      pick = t[2] ? 3 : 2;
    end else begin
      pick = t[1] ? 1 : 0;
    end
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!model_valid[s][w]) begin
        pick = w;
      end
    end
    return pick;
  endfunction

  // root and leaf point away from the way just used
  task automatic model_touch(input icache_cfg_pkg::index_t s, input int w);
    model_tree[s][0] = (w < 2);
    if (w < 2) begin
      model_tree[s][1] = (w == 0);
    end else begin
      model_tree[s][2] = (w == 2);
    end
  endtask

  task automatic wait_for_sweep();
    int waited;
    waited = 0;
    for (int s = 0; s < SETS; s++) begin
      model_tree[s] = '0;
      for (int w = 0; w < WAYS; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w] = '0;
      end
    end
    @(negedge clk_i);
    expect_equal(fetch_ready_o, 1'b0, "fetch_ready_o right after reset");
    while (!fetch_ready_o) begin
      expect_equal(data_v_o, 1'b0, "data_v_o during the tag sweep");
      expect_equal(miss_req_v_o, 1'b0, "miss_req_v_o during the tag sweep");
      waited++;
      if (waited > SETS + 2) begin
        abort_run("fetch_ready_o did not rise after the tag sweep");
      end
      @(negedge clk_i);
    end
  endtask

  task automatic run_fetch_list();
    int next_idx;
    int n_done;
    int cyc;
    int beats_left;
    int beat_no;
    int gap;
    int idx;
    int acc;
    int way;
    int fill_way;
    int q_idx[$];
    int q_cyc[$];
    icache_cfg_pkg::addr_t a;
    icache_cfg_pkg::addr_t fill_line;
    next_idx = 0;
    n_done = 0;
    cyc = 0;
    beats_left = 0;
    beat_no = 0;
    gap = 0;
    fill_way = 0;
    fill_line = '0;
    while (n_done < N_FETCH) begin
      @(posedge clk_i);
      cyc++;
      #1;
      // memory side, one beat per cycle after a random gap
      fill_v_i = 1'b0;
      if (beats_left > 0) begin
        if (gap > 0) begin
          gap--;
        end else begin
          fill_v_i = 1'b1;
          fill_i.data = image_word(fill_line + beat_no * 4);
          beat_no++;
          beats_left--;
          rng_state = xorshift32(rng_state);
          gap = rng_state % 3;
          if (beats_left == 0) begin
            model_valid[set_of(fill_line)][fill_way] = 1'b1;
            model_tag[set_of(fill_line)][fill_way] = tag_of(fill_line);
            model_touch(set_of(fill_line), fill_way);
          end
        end
      end
      fetch_v_i = (next_idx < N_FETCH);
      if (next_idx < N_FETCH) begin
        fetch_addr_i = golden[IMAGE_WORDS + 2 * next_idx];
      end
      @(negedge clk_i);
      if (data_v_o) begin
        if (q_idx.size() == 0) begin
          abort_run("data_v_o high with no fetch in flight");
        end
        idx = q_idx.pop_front();
        acc = q_cyc.pop_front();
        a = golden[IMAGE_WORDS + 2 * idx];
        way = model_hit_way(a);
        expect_equal(cyc - acc, 2, "cycles from acceptance to data_v_o");
        expect_equal(data_o, golden[IMAGE_WORDS + 2 * idx + 1], "fetched word");
        expect_equal(way >= 0, 1'b1, "hit on a line the model holds");
        model_touch(set_of(a), way);
        n_done++;
      end
      if (miss_req_v_o) begin
        if ((q_idx.size() == 0) || (beats_left > 0)) begin
          abort_run("miss request with no fetch in flight or during a fill");
        end
        idx = q_idx.pop_front();
        acc = q_cyc.pop_front();
        a = golden[IMAGE_WORDS + 2 * idx];
        expect_equal(cyc - acc, 2, "cycles from acceptance to miss_req_v_o");
        expect_equal(model_hit_way(a) < 0, 1'b1, "miss on a line the model does not hold");
        expect_equal(miss_req_o.addr, {a[31:4], 4'b0}, "miss request line address");
        expect_equal(miss_req_o.way, model_victim(set_of(a)), "replacement way");
        // the fetch behind the miss is squashed, both get reissued
        q_idx.delete();
        q_cyc.delete();
        next_idx = idx;
        fill_line = {a[31:4], 4'b0};
        fill_way = model_victim(set_of(a));
        beats_left = 4;
        beat_no = 0;
        rng_state = xorshift32(rng_state);
        gap = rng_state % 3;
      end
      if (fetch_v_i && fetch_ready_o) begin
        q_idx.push_back(next_idx);
        q_cyc.push_back(cyc);
        next_idx++;
      end
    end
    fetch_v_i = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog timeout, the cache stopped returning fetches");
  end

  initial begin
    reset_i = 1'b1;
    fetch_v_i = 1'b0;
    fetch_addr_i = '0;
    fill_v_i = 1'b0;
    fill_i = '0;
    rng_state = 32'h7372c795;
    $readmemh("bench/icache_golden.hex", golden);
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    wait_for_sweep();
    run_fetch_list();
    repeat (2) @(posedge clk_i);
    if (dut0.asrt0.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("a protocol assertion failed during the run");
      $display("TEST RESULT: FAIL");
      $fatal(1, "protocol assertion failure");
    end
  end

endmodule

// ==== hw/icache_cfg_pkg.sv ====
// instruction cache geometry
package icache_cfg_pkg;

  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int WAYS = 4;
  localparam int SETS = 64;
  localparam int WORDS_PER_LINE = WAYS;

  localparam int INDEX_W = 6;
  localparam int OFFSET_W = 2;
  localparam int TAG_W = 22;
  localparam int WAY_W = 2;
  localparam int LRU_W = 3;

  // byte address layout: tag | index | word offset | byte
  localparam int OFFSET_LSB = 2;
  localparam int INDEX_LSB = OFFSET_LSB + OFFSET_W;
  localparam int TAG_LSB = INDEX_LSB + INDEX_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [WAY_W-1:0] way_t;
  typedef logic [WAYS-1:0] way_mask_t;

  // tree bits: [0] root, [1] ways 0/1, [2] ways 2/3
  typedef logic [LRU_W-1:0] lru_t;

endpackage

// ==== hw/icache_lookup_pipe.sv ====
// two stage tag and data lookup
`timescale 1ns/1ns

module icache_lookup_pipe (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          fetch_v_i,
  input  icache_cfg_pkg::addr_t         fetch_addr_i,
  input  logic                          fetch_ready_i,
  input  logic                          squash_i,
  input  icache_msg_pkg::fill_wr_s      fill_wr_i,
  input  icache_msg_pkg::sweep_wr_s     sweep_wr_i,
  output logic                          data_v_o,
  output icache_cfg_pkg::word_t         data_o,
  output logic                          tv_v_o,
  output logic                          tv_miss_o,
  output icache_cfg_pkg::way_t          tv_hit_way_o,
  output icache_cfg_pkg::way_mask_t     tv_valid_o,
  output icache_cfg_pkg::addr_t         tv_addr_o
);

  localparam int WAYS = icache_cfg_pkg::WAYS;
  localparam int BANK_ELS = icache_cfg_pkg::SETS * icache_cfg_pkg::WORDS_PER_LINE;
  localparam int BANK_AW = $clog2(BANK_ELS);

  logic accept;
  icache_cfg_pkg::index_t f_index;
  icache_cfg_pkg::offset_t f_offset;
  icache_cfg_pkg::offset_t fill_bank;

  icache_msg_pkg::tag_entry_s tag_wdata;
  icache_msg_pkg::tag_entry_s [WAYS-1:0] tag_rdata;
  icache_cfg_pkg::word_t [WAYS-1:0] bank_rdata;

  logic tl_v_r;
  icache_cfg_pkg::addr_t tl_addr_r;
  logic tv_v_r;
  icache_cfg_pkg::addr_t tv_addr_r;
  icache_msg_pkg::tag_entry_s [WAYS-1:0] tv_tags_r;
  icache_cfg_pkg::word_t [WAYS-1:0] tv_banks_r;

  icache_cfg_pkg::tag_t tv_tag;
  icache_cfg_pkg::offset_t tv_offset;
  icache_cfg_pkg::way_mask_t hit_mask;
  icache_cfg_pkg::way_t hit_way;
  icache_cfg_pkg::word_t [WAYS-1:0] way_words;

  assign accept = fetch_v_i && fetch_ready_i;
  assign f_index = fetch_addr_i[icache_cfg_pkg::INDEX_LSB +: icache_cfg_pkg::INDEX_W];
  assign f_offset = fetch_addr_i[icache_cfg_pkg::OFFSET_LSB +: icache_cfg_pkg::OFFSET_W];

  // word b of way w sits in bank (b + w) mod 4
  assign fill_bank = fill_wr_i.offset + fill_wr_i.way;

  assign tag_wdata.valid = !sweep_wr_i.inv;
  assign tag_wdata.tag = sweep_wr_i.inv ? '0 : fill_wr_i.tag;

  for (genvar w = 0; w < WAYS; w++) begin : g_tag
    logic wr;
    icache_cfg_pkg::index_t addr;

    assign wr = !accept && (sweep_wr_i.inv ||
                (fill_wr_i.we && fill_wr_i.tag_we && (fill_wr_i.way == w)));
    assign addr = accept ? f_index : (sweep_wr_i.inv ? sweep_wr_i.index : fill_wr_i.index);

    icache_sram_1rw #(
      .ENTRY_T (icache_msg_pkg::tag_entry_s),
      .ELS     (icache_cfg_pkg::SETS)
    ) tag_mem (
      .clk_i   (clk_i),
      .en_i    (accept || wr),
      .we_i    (wr),
      .addr_i  (addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );
  end

  for (genvar b = 0; b < WAYS; b++) begin : g_bank
    logic wr;
    logic [BANK_AW-1:0] addr;

    assign wr = !accept && fill_wr_i.we && (fill_bank == b);
    assign addr = accept ? {f_index, f_offset} : {fill_wr_i.index, fill_wr_i.offset};

    icache_sram_1rw #(
      .ENTRY_T (icache_cfg_pkg::word_t),
      .ELS     (BANK_ELS)
    ) data_mem (
      .clk_i   (clk_i),
      .en_i    (accept || wr),
      .we_i    (wr),
      .addr_i  (addr),
      .wdata_i (fill_wr_i.data),
      .rdata_o (bank_rdata[b])
    );
  end

  // TL stage, memories are reading
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
      tv_v_r <= 1'b0;
    end else begin
      tl_v_r <= accept;
      tv_v_r <= tl_v_r && !squash_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tl_addr_r <= fetch_addr_i;
    end
    if (tl_v_r) begin
      tv_addr_r <= tl_addr_r;
      tv_tags_r <= tag_rdata;
      tv_banks_r <= bank_rdata;
    end
  end

  // TV stage, compare and select
  assign tv_tag = tv_addr_r[icache_cfg_pkg::TAG_LSB +: icache_cfg_pkg::TAG_W];
  assign tv_offset = tv_addr_r[icache_cfg_pkg::OFFSET_LSB +: icache_cfg_pkg::OFFSET_W];

  always_comb begin
    hit_way = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      hit_mask[w] = tv_tags_r[w].valid && (tv_tags_r[w].tag == tv_tag);
      tv_valid_o[w] = tv_tags_r[w].valid;
      way_words[w] = tv_banks_r[icache_cfg_pkg::offset_t'(tv_offset + w)];
      if (hit_mask[w]) begin
        hit_way = icache_cfg_pkg::way_t'(w);
      end
    end
  end

  assign data_v_o = tv_v_r && (|hit_mask);
  assign data_o = way_words[hit_way];
  assign tv_v_o = tv_v_r;
  assign tv_miss_o = tv_v_r && !(|hit_mask);
  assign tv_hit_way_o = hit_way;
  assign tv_addr_o = tv_addr_r;

endmodule

// ==== hw/icache_miss_fsm.sv ====
// sweep, miss and fill control
`timescale 1ns/1ns

module icache_miss_fsm (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        tv_miss_i,
  input  icache_cfg_pkg::addr_t       miss_addr_i,
  input  icache_cfg_pkg::way_t        victim_i,
  input  logic                        fill_v_i,
  input  icache_msg_pkg::fill_beat_s  fill_i,
  input  logic                        sweep_last_i,
  input  logic                        fill_last_i,
  input  icache_cfg_pkg::index_t      sweep_idx_i,
  input  icache_cfg_pkg::offset_t     fill_cnt_i,
  output logic                        sweep_start_o,
  output logic                        sweep_step_o,
  output logic                        fill_start_o,
  output logic                        fill_step_o,
  output logic                        fetch_ready_o,
  output logic                        squash_o,
  output logic                        miss_req_v_o,
  output icache_msg_pkg::miss_req_s   miss_req_o,
  output icache_msg_pkg::fill_wr_s    fill_wr_o,
  output icache_msg_pkg::sweep_wr_s   sweep_wr_o
);

  typedef enum logic [1:0] {
    SWEEP,
    IDLE,
    FILL
  } state_e;

  state_e state_r;
  icache_cfg_pkg::addr_t line_addr_r;
  icache_cfg_pkg::way_t way_r;
  logic miss_take;

  assign miss_take = (state_r == IDLE) && tv_miss_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= SWEEP;
    end else begin
      case (state_r)
        SWEEP: if (sweep_last_i) state_r <= IDLE;
        IDLE: if (tv_miss_i) state_r <= FILL;
        FILL: if (fill_v_i && fill_last_i) state_r <= IDLE;
        default: state_r <= SWEEP;
      endcase
    end
  end

  // line and victim stay fixed for the whole fill
  always_ff @(posedge clk_i) begin
    if (miss_take) begin
      line_addr_r <= miss_req_o.addr;
      way_r <= victim_i;
    end
  end

  assign sweep_start_o = (state_r != SWEEP);
  assign sweep_step_o = (state_r == SWEEP);
  assign sweep_wr_o.inv = (state_r == SWEEP);
  assign sweep_wr_o.index = sweep_idx_i;

  assign fetch_ready_o = (state_r == IDLE) && !tv_miss_i;
  assign squash_o = miss_take;

  assign miss_req_v_o = miss_take;
  assign miss_req_o.addr = {miss_addr_i[icache_cfg_pkg::ADDR_W-1:icache_cfg_pkg::INDEX_LSB],
                            icache_cfg_pkg::INDEX_LSB'(0)};
  assign miss_req_o.way = victim_i;

  assign fill_start_o = miss_take;
  assign fill_step_o = (state_r == FILL) && fill_v_i;

  // beats land at the counter offset, tag goes with the last one
  assign fill_wr_o.we = fill_step_o;
  assign fill_wr_o.index = line_addr_r[icache_cfg_pkg::INDEX_LSB +: icache_cfg_pkg::INDEX_W];
  assign fill_wr_o.way = way_r;
  assign fill_wr_o.offset = fill_cnt_i;
  assign fill_wr_o.data = fill_i.data;
  assign fill_wr_o.tag_we = fill_last_i;
  assign fill_wr_o.tag = line_addr_r[icache_cfg_pkg::TAG_LSB +: icache_cfg_pkg::TAG_W];

endmodule

// ==== hw/icache_msg_pkg.sv ====
// instruction cache message structs
package icache_msg_pkg;

  // one way of a tag set
  typedef struct packed {
    logic valid;
    icache_cfg_pkg::tag_t tag;
  } tag_entry_s;

  // line request toward the memory side
  typedef struct packed {
    icache_cfg_pkg::addr_t addr;
    icache_cfg_pkg::way_t way;
  } miss_req_s;

  // beat number comes from arrival order
  typedef struct packed {
    icache_cfg_pkg::word_t data;
  } fill_beat_s;

  // one fill word, plus the tag on the last beat
  typedef struct packed {
    logic we;
    icache_cfg_pkg::index_t index;
    icache_cfg_pkg::way_t way;
    icache_cfg_pkg::offset_t offset;
    icache_cfg_pkg::word_t data;
    logic tag_we;
    icache_cfg_pkg::tag_t tag;
  } fill_wr_s;

  // invalidate all ways of one set
  typedef struct packed {
    logic inv;
    icache_cfg_pkg::index_t index;
  } sweep_wr_s;

endpackage

// ==== hw/icache_replace.sv ====
// pseudo-LRU state and victim choice
`timescale 1ns/1ns

module icache_replace (
  input  logic                       clk_i,
  input  logic                       tv_v_i,
  input  logic                       tv_miss_i,
  input  icache_cfg_pkg::way_t       tv_hit_way_i,
  input  icache_cfg_pkg::way_mask_t  tv_valid_i,
  input  icache_cfg_pkg::index_t     tv_index_i,
  input  icache_msg_pkg::fill_wr_s   fill_wr_i,
  input  icache_msg_pkg::sweep_wr_s  sweep_wr_i,
  output icache_cfg_pkg::way_t       victim_o
);

  icache_cfg_pkg::lru_t lru_r [icache_cfg_pkg::SETS];
  icache_cfg_pkg::lru_t lru_cur;
  icache_cfg_pkg::way_t lru_way;
  icache_cfg_pkg::way_t invalid_way;
  logic invalid_found;

  logic upd_v;
  icache_cfg_pkg::index_t upd_index;
  icache_cfg_pkg::way_t upd_way;
  icache_cfg_pkg::lru_t upd_bits;

  // bits are read in the TV cycle so the victim is ready with the miss
  assign lru_cur = lru_r[tv_index_i];

  // root 1 points at the right pair
  assign lru_way = lru_cur[0] ? {1'b1, lru_cur[2]} : {1'b0, lru_cur[1]};

  always_comb begin
    invalid_found = 1'b0;
    invalid_way = '0;
    for (int w = icache_cfg_pkg::WAYS - 1; w >= 0; w--) begin
      if (!tv_valid_i[w]) begin
        invalid_found = 1'b1;
        invalid_way = icache_cfg_pkg::way_t'(w);
      end
    end
  end

  assign victim_o = invalid_found ? invalid_way : lru_way;

  // the tag write of a fill and a hit never share a cycle
  assign upd_v = (tv_v_i && !tv_miss_i) || (fill_wr_i.we && fill_wr_i.tag_we);
  assign upd_index = fill_wr_i.tag_we ? fill_wr_i.index : tv_index_i;
  assign upd_way = fill_wr_i.tag_we ? fill_wr_i.way : tv_hit_way_i;

  // point the tree away from the way just used
  always_comb begin
    upd_bits = lru_r[upd_index];
    upd_bits[0] = !upd_way[1];
    if (upd_way[1]) begin
      upd_bits[2] = !upd_way[0];
    end else begin
      upd_bits[1] = !upd_way[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (sweep_wr_i.inv) begin
      lru_r[sweep_wr_i.index] <= '0;
    end else if (upd_v) begin
      lru_r[upd_index] <= upd_bits;
    end
  end

endmodule

// ==== hw/icache_sram_1rw.sv ====
// single port synchronous memory
`timescale 1ns/1ns

module icache_sram_1rw #(
  parameter type ENTRY_T = logic [31:0],
  parameter int ELS = 64
) (
  input  logic                   clk_i,
  input  logic                   en_i,
  input  logic                   we_i,
  input  logic [$clog2(ELS)-1:0] addr_i,
  input  ENTRY_T                 wdata_i,
  output ENTRY_T                 rdata_o
);

  ENTRY_T mem [ELS];
  ENTRY_T rdata_r;

  // read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_r <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdata_r;

endmodule

// ==== hw/icache_step_counter.sv ====
// step counter with last flag
`timescale 1ns/1ns

module icache_step_counter #(
  parameter int COUNT = 4
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     start_i,
  input  logic                     step_i,
  output logic [$clog2(COUNT)-1:0] count_o,
  output logic                     last_o
);

  localparam int CNT_W = $clog2(COUNT);
  localparam logic [CNT_W-1:0] LAST_VAL = CNT_W'(COUNT - 1);

  logic [CNT_W-1:0] count_r;

  // start wins over step
  always_ff @(posedge clk_i) begin
    if (reset_i || start_i) begin
      count_r <= '0;
    end else if (step_i) begin
      count_r <= count_r + 1'b1;
    end
  end

  assign count_o = count_r;
  assign last_o = (count_r == LAST_VAL);

endmodule

// ==== hw/icache_top.sv ====
// instruction cache top
`timescale 1ns/1ns

module icache_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        fetch_v_i,
  input  icache_cfg_pkg::addr_t       fetch_addr_i,
  output logic                        fetch_ready_o,
  output logic                        data_v_o,
  output icache_cfg_pkg::word_t       data_o,
  output logic                        miss_req_v_o,
  output icache_msg_pkg::miss_req_s   miss_req_o,
  input  logic                        fill_v_i,
  input  icache_msg_pkg::fill_beat_s  fill_i
);

  logic squash;
  logic tv_v;
  logic tv_miss;
  icache_cfg_pkg::way_t tv_hit_way;
  icache_cfg_pkg::way_mask_t tv_valid;
  icache_cfg_pkg::addr_t tv_addr;
  icache_cfg_pkg::way_t victim;
  icache_msg_pkg::fill_wr_s fill_wr;
  icache_msg_pkg::sweep_wr_s sweep_wr;

  logic sweep_start, sweep_step, sweep_last;
  logic fill_start, fill_step, fill_last;
  icache_cfg_pkg::index_t sweep_idx;
  icache_cfg_pkg::offset_t fill_cnt;

  icache_lookup_pipe pipe0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_i (fetch_ready_o),
    .squash_i      (squash),
    .fill_wr_i     (fill_wr),
    .sweep_wr_i    (sweep_wr),
    .data_v_o      (data_v_o),
    .data_o        (data_o),
    .tv_v_o        (tv_v),
    .tv_miss_o     (tv_miss),
    .tv_hit_way_o  (tv_hit_way),
    .tv_valid_o    (tv_valid),
    .tv_addr_o     (tv_addr)
  );

  icache_replace repl0 (
    .clk_i        (clk_i),
    .tv_v_i       (tv_v),
    .tv_miss_i    (tv_miss),
    .tv_hit_way_i (tv_hit_way),
    .tv_valid_i   (tv_valid),
    .tv_index_i   (tv_addr[icache_cfg_pkg::INDEX_LSB +: icache_cfg_pkg::INDEX_W]),
    .fill_wr_i    (fill_wr),
    .sweep_wr_i   (sweep_wr),
    .victim_o     (victim)
  );

  icache_miss_fsm fsm0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .tv_miss_i     (tv_miss),
    .miss_addr_i   (tv_addr),
    .victim_i      (victim),
    .fill_v_i      (fill_v_i),
    .fill_i        (fill_i),
    .sweep_last_i  (sweep_last),
    .fill_last_i   (fill_last),
    .sweep_idx_i   (sweep_idx),
    .fill_cnt_i    (fill_cnt),
    .sweep_start_o (sweep_start),
    .sweep_step_o  (sweep_step),
    .fill_start_o  (fill_start),
    .fill_step_o   (fill_step),
    .fetch_ready_o (fetch_ready_o),
    .squash_o      (squash),
    .miss_req_v_o  (miss_req_v_o),
    .miss_req_o    (miss_req_o),
    .fill_wr_o     (fill_wr),
    .sweep_wr_o    (sweep_wr)
  );

  icache_step_counter #(.COUNT(icache_cfg_pkg::SETS)) sweep_cnt0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (sweep_start),
    .step_i  (sweep_step),
    .count_o (sweep_idx),
    .last_o  (sweep_last)
  );

  icache_step_counter #(.COUNT(icache_cfg_pkg::WORDS_PER_LINE)) fill_cnt0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (fill_start),
    .step_i  (fill_step),
    .count_o (fill_cnt),
    .last_o  (fill_last)
  );

endmodule
